// File: qeciphy_rx_align.f
rtl/qeciphy_rx_word_pkg.sv
rtl/qeciphy_rx_ctrl_pkg.sv
rtl/qeciphy_comma_decoder.sv
rtl/qeciphy_align_tracker.sv
rtl/qeciphy_align_retry_ctrl.sv
rtl/qeciphy_rx_align.sv
dv/tb_qeciphy_rx_align.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the receive alignment testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb_qeciphy_rx_align
LOG=sim.log

verilator --binary --timing -Wno-fatal \
   --top-module tb_qeciphy_rx_align \
   -f qeciphy_rx_align.f \
   --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: dv/tb_qeciphy_rx_align.sv
// ----------------------------------------
// Receive alignment control testbench
// LFSR streams checked against a cycle model
// ----------------------------------------

`timescale 1ns/1ps

module tb_qeciphy_rx_align;

   localparam int PAT_LEN    = 8;
   localparam int REVIEWS    = 4;
   localparam int RETRIES    = 3;
   localparam int RST_CYCLES = 16;
   localparam int STREAMS    = 18;
   localparam int STREAM_CYCLES = (REVIEWS + 3) * PAT_LEN + 16;
   localparam int RETRY_SPAN = qeciphy_rx_ctrl_pkg::RST_HOLD_CYCLES + 8;
   // Every stream may wait out one retry span, doubled for margin
   localparam int LIMIT_CYCLES = 2 * (RST_CYCLES + STREAMS * (STREAM_CYCLES + RETRY_SPAN));
   localparam logic [7:0] COMMA = qeciphy_rx_word_pkg::COMMA_K28_5;

   logic                            rx_clk_2x_o = 1'b0;
   logic                            gt_rst_n_i;
   logic                            gt_rx_rst_done_i;
   logic                            rx_byte_realign_i;
   qeciphy_rx_word_pkg::rx_word_t   rx_tdata_i;
   logic                            gt_rx_rst_done_o;
   logic                            rx_comma_align_en_o;
   logic                            rx_datapath_resetn_o;
   logic                            rx_byte_aligned_o;
   logic                            rx_align_failed_o;
   qeciphy_rx_ctrl_pkg::retry_cnt_t rx_retry_count_o;

   // Reference model state
   logic                              exp_done    = 1'b0;
   logic                              exp_en      = 1'b0;
   logic                              exp_resetn  = 1'b1;
   logic                              exp_aligned = 1'b0;
   logic                              exp_failed  = 1'b0;
   qeciphy_rx_ctrl_pkg::retry_cnt_t   exp_retry   = '0;
   qeciphy_rx_ctrl_pkg::verdict_t     exp_verdict = qeciphy_rx_ctrl_pkg::VERDICT_NONE;
   qeciphy_rx_ctrl_pkg::track_state_t trk_mode    = qeciphy_rx_ctrl_pkg::TRK_IDLE;
   int                                low_cycles  = 0;
   int                                since_comma = 0;
   int                                reviews     = 0;
   qeciphy_rx_word_pkg::rx_word_t     word_d1     = '0;
   qeciphy_rx_word_pkg::rx_word_t     word_d2     = '0;
   logic                              realign_d1  = 1'b0;

   int          done_errs   = 0;
   int          status_errs = 0;
   int          retry_errs  = 0;
   logic [15:0] lfsr_state  = 16'd61114;

   qeciphy_rx_align #(
      .TX_PATTERN_LENGTH(PAT_LEN),
      .MAX_REVIEWS      (REVIEWS),
      .MAX_RETRIES      (RETRIES)
   ) dut_i (
      .rx_clk_2x_o         (rx_clk_2x_o),
      .gt_rst_n_i          (gt_rst_n_i),
      .gt_rx_rst_done_i    (gt_rx_rst_done_i),
      .rx_byte_realign_i   (rx_byte_realign_i),
      .rx_tdata_i          (rx_tdata_i),
      .gt_rx_rst_done_o    (gt_rx_rst_done_o),
      .rx_comma_align_en_o (rx_comma_align_en_o),
      .rx_datapath_resetn_o(rx_datapath_resetn_o),
      .rx_byte_aligned_o   (rx_byte_aligned_o),
      .rx_align_failed_o   (rx_align_failed_o),
      .rx_retry_count_o    (rx_retry_count_o)
   );

   initial begin
      forever #50 rx_clk_2x_o = ~rx_clk_2x_o;
   end

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic check_done(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         done_errs++;
         $display("[FAIL] %0t ns %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_status(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         status_errs++;
         $display("[FAIL] %0t ns %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_retry(input qeciphy_rx_ctrl_pkg::retry_cnt_t got,
                              input qeciphy_rx_ctrl_pkg::retry_cnt_t exp, input string what);
      if (got !== exp) begin
         retry_errs++;
         $display("[FAIL] %0t ns %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // ----------------------------------------
   // Random source and word builders
   // ----------------------------------------
   // Taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
   endtask

   // Lowest lane holding a comma, or -1
   function automatic int comma_lane_of(input qeciphy_rx_word_pkg::rx_word_t w);
      for (int l = 0; l < qeciphy_rx_word_pkg::RX_LANES; l++) begin
         if (w[8*l +: 8] == COMMA) begin
            return l;
         end
      end
      return -1;
   endfunction

   task automatic make_filler(output qeciphy_rx_word_pkg::rx_word_t w);
      logic [31:0] r;
      draw_bits(32, r);
      for (int l = 0; l < qeciphy_rx_word_pkg::RX_LANES; l++) begin
         if (r[8*l +: 8] == COMMA) begin
            r[8*l +: 8] = 8'h3C;
         end
      end
      w = r;
   endtask

   task automatic send_word(input qeciphy_rx_word_pkg::rx_word_t w, input logic realign);
      @(negedge rx_clk_2x_o);
      rx_tdata_i        = w;
      rx_byte_realign_i = realign;
   endtask

   task automatic send_fillers(input int n);
      qeciphy_rx_word_pkg::rx_word_t w;
      for (int i = 0; i < n; i++) begin
         make_filler(w);
         send_word(w, 1'b0);
      end
   endtask

   // Periodic lane 0 commas; fault 1 wrong lane, 2 dropped comma, 3 realign pulse
   task automatic run_stream(input int periods, input int fault, input logic wait_run);
      logic [31:0]                   r;
      int                            fault_period;
      qeciphy_rx_word_pkg::rx_word_t w;
      while (wait_run && !(exp_done && exp_resetn && !exp_aligned && !exp_failed)) begin
         send_fillers(1);
      end
      draw_bits(3, r);
      send_fillers(int'(r[2:0]) % 5);
      draw_bits(2, r);
      fault_period = 1 + int'(r[1:0]) % 3;
      for (int p = 0; p < periods; p++) begin
         make_filler(w);
         if (!(fault == 2 && p == fault_period)) begin
            draw_bits(2, r);
            if (fault == 1 && p == fault_period) begin
               w[8*(1 + int'(r[1:0]) % 3) +: 8] = COMMA;
            end else begin
               w[7:0] = COMMA;
            end
         end
         send_word(w, 1'b0);
         for (int i = 1; i < PAT_LEN; i++) begin
            make_filler(w);
            send_word(w, fault == 3 && p == fault_period && i == 3);
         end
         if (fault != 0 && p == fault_period) begin
            break;
         end
      end
      send_fillers(PAT_LEN);
   endtask

   task automatic cycle_rst_done();
      gt_rx_rst_done_i = 1'b0;
      send_fillers(4);
      check_status(rx_byte_aligned_o, 1'b0, "aligned after reset-done drop");
      check_status(rx_align_failed_o, 1'b0, "failed after reset-done drop");
      check_retry(rx_retry_count_o, '0, "retry count after reset-done drop");
      gt_rx_rst_done_i = 1'b1;
      send_fillers(1);
   endtask

   // ----------------------------------------
   // Cycle model, 3 cycles from word to status
   // ----------------------------------------
   always @(posedge rx_clk_2x_o) begin
      int                            lane;
      logic                          run;
      logic                          en_next;
      qeciphy_rx_ctrl_pkg::verdict_t v;
      lane    = comma_lane_of(word_d2);
      run     = exp_done && exp_resetn && !exp_aligned && !exp_failed;
      en_next = exp_done && !exp_aligned;
      v       = qeciphy_rx_ctrl_pkg::VERDICT_NONE;
      if (!gt_rst_n_i) begin
         exp_done    = 1'b0;
         exp_en      = 1'b0;
         exp_resetn  = 1'b1;
         exp_aligned = 1'b0;
         exp_failed  = 1'b0;
         exp_retry   = '0;
         trk_mode    = qeciphy_rx_ctrl_pkg::TRK_IDLE;
      end else begin
         // Stream rules on the word leaving the decoder
         if (!run) begin
            trk_mode = qeciphy_rx_ctrl_pkg::TRK_IDLE;
         end else if (trk_mode == qeciphy_rx_ctrl_pkg::TRK_IDLE) begin
            trk_mode    = qeciphy_rx_ctrl_pkg::TRK_SEEK;
            since_comma = 0;
            reviews     = 0;
         end else if (trk_mode == qeciphy_rx_ctrl_pkg::TRK_SEEK) begin
            since_comma++;
            if (lane > 0 || (lane < 0 && since_comma == PAT_LEN)) begin
               v = qeciphy_rx_ctrl_pkg::VERDICT_FAIL;
            end else if (lane == 0) begin
               trk_mode    = qeciphy_rx_ctrl_pkg::TRK_REVIEW;
               since_comma = 0;
            end
         end else if (trk_mode == qeciphy_rx_ctrl_pkg::TRK_REVIEW) begin
            since_comma++;
            if (realign_d1 || lane > 0 || ((lane == 0) != (since_comma == PAT_LEN))) begin
               v = qeciphy_rx_ctrl_pkg::VERDICT_FAIL;
            end else if (lane == 0) begin
               since_comma = 0;
               reviews++;
               if (reviews == REVIEWS) begin
                  v = qeciphy_rx_ctrl_pkg::VERDICT_PASS;
               end
            end
         end
         if (v != qeciphy_rx_ctrl_pkg::VERDICT_NONE) begin
            trk_mode = qeciphy_rx_ctrl_pkg::TRK_DONE;
         end
         // Status follows last cycle's verdict
         if (!exp_done) begin
            exp_aligned = 1'b0;
            exp_failed  = 1'b0;
            exp_retry   = '0;
            exp_resetn  = 1'b1;
         end else begin
            if (!exp_resetn) begin
               low_cycles++;
               exp_resetn = (low_cycles == qeciphy_rx_ctrl_pkg::RST_HOLD_CYCLES);
            end
            if (exp_verdict == qeciphy_rx_ctrl_pkg::VERDICT_PASS) begin
               exp_aligned = 1'b1;
            end else if (exp_verdict == qeciphy_rx_ctrl_pkg::VERDICT_FAIL) begin
               exp_retry = exp_retry + 1'b1;
               if (exp_retry == qeciphy_rx_ctrl_pkg::retry_cnt_t'(RETRIES)) begin
                  exp_failed = 1'b1;
               end else begin
                  exp_resetn = 1'b0;
                  low_cycles = 0;
               end
            end
         end
         exp_en   = en_next;
         exp_done = gt_rx_rst_done_i;
      end
      exp_verdict = v;
      word_d2     = word_d1;
      word_d1     = rx_tdata_i;
      realign_d1  = rx_byte_realign_i;
   end

   // Outputs are compared where they are stable
   always @(negedge rx_clk_2x_o) begin
      check_done(gt_rx_rst_done_o, exp_done, "gt_rx_rst_done_o");
      check_status(rx_comma_align_en_o, exp_en, "rx_comma_align_en_o");
      check_status(rx_datapath_resetn_o, exp_resetn, "rx_datapath_resetn_o");
      check_status(rx_byte_aligned_o, exp_aligned, "rx_byte_aligned_o");
      check_status(rx_align_failed_o, exp_failed, "rx_align_failed_o");
      check_retry(rx_retry_count_o, exp_retry, "rx_retry_count_o");
   end

   initial begin
      repeat (LIMIT_CYCLES) @(posedge rx_clk_2x_o);
      $display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      logic [31:0] r;
      gt_rst_n_i        = 1'b0;
      gt_rx_rst_done_i  = 1'b0;
      rx_byte_realign_i = 1'b0;
      rx_tdata_i        = '0;
      repeat (RST_CYCLES) @(negedge rx_clk_2x_o);
      gt_rst_n_i = 1'b1;
      send_fillers(4);

      // Reset-done capture, then comma align enable
      gt_rx_rst_done_i = 1'b1;
      send_fillers(1);
      check_done(gt_rx_rst_done_o, 1'b1, "captured reset-done");
      check_status(rx_comma_align_en_o, 1'b0, "comma align enable one cycle early");
      send_fillers(1);
      check_status(rx_comma_align_en_o, 1'b1, "comma align enable");

      // Clean stream
      run_stream(REVIEWS + 2, 0, 1'b1);
      check_status(rx_byte_aligned_o, 1'b1, "aligned on clean stream");
      check_status(rx_comma_align_en_o, 1'b0, "comma align enable when aligned");

      // Wrong lane, dropped comma and realign, each followed by a clean retry
      for (int kind = 1; kind <= 3; kind++) begin
         for (int rep = 0; rep < 2; rep++) begin
            cycle_rst_done();
            run_stream(REVIEWS + 2, kind, 1'b1);
            check_retry(rx_retry_count_o, 6'd1, "retry count after one fail");
            run_stream(REVIEWS + 2, 0, 1'b1);
            check_status(rx_byte_aligned_o, 1'b1, "aligned after retry");
         end
      end

      // Retries exhausted
      cycle_rst_done();
      for (int n = 0; n < RETRIES; n++) begin
         draw_bits(2, r);
         run_stream(REVIEWS + 2, 1 + int'(r[1:0]) % 3, 1'b1);
      end
      check_status(rx_align_failed_o, 1'b1, "failed after last retry");
      check_retry(rx_retry_count_o, 6'(RETRIES), "retry count at give-up");
      run_stream(REVIEWS + 2, 0, 1'b0);
      check_status(rx_byte_aligned_o, 1'b0, "aligned while failed");
      check_status(rx_datapath_resetn_o, 1'b1, "datapath reset while failed");

      // Reset-done drop clears the failure
      cycle_rst_done();
      run_stream(REVIEWS + 2, 0, 1'b1);
      check_status(rx_byte_aligned_o, 1'b1, "aligned after reset-done cycle");

      $display("Errors: reset-done %0d, status %0d, retry count %0d",
               done_errs, status_errs, retry_errs);
      if (done_errs + status_errs + retry_errs == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: rtl/qeciphy_rx_align.sv
// ----------------------------------------
// Receive alignment control top level
// Decoder, tracker and retry controller in a chain
// ----------------------------------------

`timescale 1ns/1ps

module qeciphy_rx_align #(
   parameter int TX_PATTERN_LENGTH = 128,
   parameter int MAX_REVIEWS       = 128,
   parameter int MAX_RETRIES       = 32
) (
   input  logic                            rx_clk_2x_o,
   input  logic                            gt_rst_n_i,
   input  logic                            gt_rx_rst_done_i,
   input  logic                            rx_byte_realign_i,
   input  qeciphy_rx_word_pkg::rx_word_t   rx_tdata_i,

   output logic                            gt_rx_rst_done_o,
   output logic                            rx_comma_align_en_o,
   output logic                            rx_datapath_resetn_o,
   output logic                            rx_byte_aligned_o,
   output logic                            rx_align_failed_o,
   output qeciphy_rx_ctrl_pkg::retry_cnt_t rx_retry_count_o
);

   logic                          comma_hit;
   qeciphy_rx_word_pkg::rx_lane_t comma_lane;
   logic                          monitor_run;
   qeciphy_rx_ctrl_pkg::verdict_t verdict;

   // Decode stage
   qeciphy_comma_decoder i_comma_decoder (
      .rx_clk_2x_o (rx_clk_2x_o),
      .gt_rst_n_i  (gt_rst_n_i),
      .rx_tdata_i  (rx_tdata_i),
      .comma_hit_o (comma_hit),
      .comma_lane_o(comma_lane)
   );

   // Execute stage
   qeciphy_align_tracker #(
      .TX_PATTERN_LENGTH(TX_PATTERN_LENGTH),
      .MAX_REVIEWS      (MAX_REVIEWS)
   ) i_align_tracker (
      .rx_clk_2x_o      (rx_clk_2x_o),
      .gt_rst_n_i       (gt_rst_n_i),
      .monitor_run_i    (monitor_run),
      .rx_byte_realign_i(rx_byte_realign_i),
      .comma_hit_i      (comma_hit),
      .comma_lane_i     (comma_lane),
      .verdict_o        (verdict)
   );

   // Result stage
   qeciphy_align_retry_ctrl #(
      .MAX_RETRIES(MAX_RETRIES)
   ) i_align_retry_ctrl (
      .rx_clk_2x_o         (rx_clk_2x_o),
      .gt_rst_n_i          (gt_rst_n_i),
      .gt_rx_rst_done_i    (gt_rx_rst_done_i),
      .verdict_i           (verdict),
      .monitor_run_o       (monitor_run),
      .gt_rx_rst_done_o    (gt_rx_rst_done_o),
      .rx_comma_align_en_o (rx_comma_align_en_o),
      .rx_datapath_resetn_o(rx_datapath_resetn_o),
      .rx_byte_aligned_o   (rx_byte_aligned_o),
      .rx_align_failed_o   (rx_align_failed_o),
      .rx_retry_count_o    (rx_retry_count_o)
   );

endmodule

// File: rtl/qeciphy_align_retry_ctrl.sv
// ----------------------------------------
// Alignment retry controller
// Reset-done capture, comma align enable and retries
// ----------------------------------------

`timescale 1ns/1ps

module qeciphy_align_retry_ctrl #(
   parameter int MAX_RETRIES = 32
) (
   input  logic                            rx_clk_2x_o,
   input  logic                            gt_rst_n_i,
   input  logic                            gt_rx_rst_done_i,
   input  qeciphy_rx_ctrl_pkg::verdict_t   verdict_i,
   output logic                            monitor_run_o,
   output logic                            gt_rx_rst_done_o,
   output logic                            rx_comma_align_en_o,
   output logic                            rx_datapath_resetn_o,
   output logic                            rx_byte_aligned_o,
   output logic                            rx_align_failed_o,
   output qeciphy_rx_ctrl_pkg::retry_cnt_t rx_retry_count_o
);

   qeciphy_rx_ctrl_pkg::hold_cnt_t  hold_cnt;
   qeciphy_rx_ctrl_pkg::retry_cnt_t retry_next;
   logic                            last_retry;
   logic                            got_pass;
   logic                            got_fail;

   assign got_pass   = (verdict_i == qeciphy_rx_ctrl_pkg::VERDICT_PASS);
   assign got_fail   = (verdict_i == qeciphy_rx_ctrl_pkg::VERDICT_FAIL);
   assign retry_next = rx_retry_count_o + 1'b1;
   assign last_retry = (retry_next == qeciphy_rx_ctrl_pkg::retry_cnt_t'(MAX_RETRIES));

   // Tracker runs only on a live, unreset and unresolved link
   assign monitor_run_o = gt_rx_rst_done_o & rx_datapath_resetn_o &
                          ~rx_byte_aligned_o & ~rx_align_failed_o;

   // ----------------------------------------
   // Transceiver handshake
   // ----------------------------------------

   // Register the raw reset-done level to filter glitches
   always_ff @(posedge rx_clk_2x_o or negedge gt_rst_n_i) begin
      if (!gt_rst_n_i) begin
         gt_rx_rst_done_o <= 1'b0;
      end else begin
         gt_rx_rst_done_o <= gt_rx_rst_done_i;
      end
   end

   // Keep the transceiver hunting for commas until aligned
   always_ff @(posedge rx_clk_2x_o or negedge gt_rst_n_i) begin
      if (!gt_rst_n_i) begin
         rx_comma_align_en_o <= 1'b0;
      end else if (rx_byte_aligned_o) begin
         rx_comma_align_en_o <= 1'b0;
      end else begin
         rx_comma_align_en_o <= gt_rx_rst_done_o;
      end
   end

   // ----------------------------------------
   // Verdict handling
   // ----------------------------------------

   // Status and retry count
   always_ff @(posedge rx_clk_2x_o or negedge gt_rst_n_i) begin
      if (!gt_rst_n_i) begin
         rx_byte_aligned_o <= 1'b0;
         rx_align_failed_o <= 1'b0;
         rx_retry_count_o  <= '0;
      end else if (!gt_rx_rst_done_o) begin
         rx_byte_aligned_o <= 1'b0;
         rx_align_failed_o <= 1'b0;
         rx_retry_count_o  <= '0;
      end else if (got_pass) begin
         rx_byte_aligned_o <= 1'b1;
      end else if (got_fail) begin
         rx_retry_count_o <= retry_next;
         if (last_retry) begin
            rx_align_failed_o <= 1'b1;
         end
      end
   end

   // Datapath reset pulse, low for RST_HOLD_CYCLES after a retryable fail
   always_ff @(posedge rx_clk_2x_o or negedge gt_rst_n_i) begin
      if (!gt_rst_n_i) begin
         rx_datapath_resetn_o <= 1'b1;
         hold_cnt             <= '0;
      end else if (!gt_rx_rst_done_o) begin
         rx_datapath_resetn_o <= 1'b1;
         hold_cnt             <= '0;
      end else if (!rx_datapath_resetn_o) begin
         if (hold_cnt == '0) begin
            rx_datapath_resetn_o <= 1'b1;
         end else begin
            hold_cnt <= hold_cnt - 1'b1;
         end
      end else if (got_fail && !last_retry) begin
         rx_datapath_resetn_o <= 1'b0;
         hold_cnt <= qeciphy_rx_ctrl_pkg::hold_cnt_t'(qeciphy_rx_ctrl_pkg::RST_HOLD_CYCLES - 1);
      end
   end

endmodule

// File: rtl/qeciphy_align_tracker.sv
// ----------------------------------------
// Alignment tracker
// Checks comma lane and spacing per pattern period
// ----------------------------------------

`timescale 1ns/1ps

module qeciphy_align_tracker #(
   parameter int TX_PATTERN_LENGTH = 128,
   parameter int MAX_REVIEWS       = 128
) (
   input  logic                            rx_clk_2x_o,
   input  logic                            gt_rst_n_i,
   input  logic                            monitor_run_i,
   input  logic                            rx_byte_realign_i,
   input  logic                            comma_hit_i,
   input  qeciphy_rx_word_pkg::rx_lane_t   comma_lane_i,
   output qeciphy_rx_ctrl_pkg::verdict_t   verdict_o
);

   localparam int WORD_CNT_W   = $clog2(TX_PATTERN_LENGTH + 1);
   localparam int REVIEW_CNT_W = $clog2(MAX_REVIEWS + 1);

   qeciphy_rx_ctrl_pkg::track_state_t state;
   logic [WORD_CNT_W-1:0]             word_cnt;
   logic [REVIEW_CNT_W-1:0]           review_cnt;
   logic                              realign_q;
   logic                              lane0_comma;
   logic                              bad_lane;
   logic                              at_boundary;
   logic                              early_comma;
   logic                              missed_comma;
   logic                              last_review;

   // Word classification
   assign lane0_comma  = comma_hit_i && (comma_lane_i == '0);
   assign bad_lane     = comma_hit_i && (comma_lane_i != '0);
   // Word count reaching one full pattern
   assign at_boundary  = (word_cnt == WORD_CNT_W'(TX_PATTERN_LENGTH - 1));
   assign early_comma  = comma_hit_i && !at_boundary;
   assign missed_comma = !comma_hit_i && at_boundary;
   assign last_review  = (review_cnt == REVIEW_CNT_W'(MAX_REVIEWS - 1));

   // Realign pulse lines up with the decoded word stream
   always_ff @(posedge rx_clk_2x_o or negedge gt_rst_n_i) begin
      if (!gt_rst_n_i) begin
         realign_q <= 1'b0;
      end else begin
         realign_q <= rx_byte_realign_i;
      end
   end

   // ----------------------------------------
   // Seek and review FSM
   // ----------------------------------------
   always_ff @(posedge rx_clk_2x_o or negedge gt_rst_n_i) begin
      if (!gt_rst_n_i) begin
         state      <= qeciphy_rx_ctrl_pkg::TRK_IDLE;
         word_cnt   <= '0;
         review_cnt <= '0;
         verdict_o  <= qeciphy_rx_ctrl_pkg::VERDICT_NONE;
      end else begin
         verdict_o <= qeciphy_rx_ctrl_pkg::VERDICT_NONE;
         if (!monitor_run_i) begin
            state <= qeciphy_rx_ctrl_pkg::TRK_IDLE;
         end else begin
            case (state)
               qeciphy_rx_ctrl_pkg::TRK_IDLE: begin
                  state      <= qeciphy_rx_ctrl_pkg::TRK_SEEK;
                  word_cnt   <= '0;
                  review_cnt <= '0;
               end
               // First lane 0 comma within one pattern
               qeciphy_rx_ctrl_pkg::TRK_SEEK: begin
                  if (bad_lane || missed_comma) begin
                     verdict_o <= qeciphy_rx_ctrl_pkg::VERDICT_FAIL;
                     state     <= qeciphy_rx_ctrl_pkg::TRK_DONE;
                  end else if (lane0_comma) begin
                     state    <= qeciphy_rx_ctrl_pkg::TRK_REVIEW;
                     word_cnt <= '0;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
               // Next comma due exactly one pattern later
               qeciphy_rx_ctrl_pkg::TRK_REVIEW: begin
                  if (realign_q || bad_lane || early_comma || missed_comma) begin
                     verdict_o <= qeciphy_rx_ctrl_pkg::VERDICT_FAIL;
                     state     <= qeciphy_rx_ctrl_pkg::TRK_DONE;
                  end else if (lane0_comma) begin
                     word_cnt   <= '0;
                     review_cnt <= review_cnt + 1'b1;
                     if (last_review) begin
                        verdict_o <= qeciphy_rx_ctrl_pkg::VERDICT_PASS;
                        state     <= qeciphy_rx_ctrl_pkg::TRK_DONE;
                     end
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
               // Wait here until the controller drops monitor_run
               qeciphy_rx_ctrl_pkg::TRK_DONE: begin
                  state <= qeciphy_rx_ctrl_pkg::TRK_DONE;
               end
               default: begin
                  state <= qeciphy_rx_ctrl_pkg::TRK_IDLE;
               end
            endcase
         end
      end
   end

endmodule

// File: rtl/qeciphy_comma_decoder.sv
// ----------------------------------------
// Comma decoder
// Flags a K28.5 in a received word and its lane
// ----------------------------------------

`timescale 1ns/1ps

module qeciphy_comma_decoder (
   input  logic                           rx_clk_2x_o,
   input  logic                           gt_rst_n_i,
   input  qeciphy_rx_word_pkg::rx_word_t  rx_tdata_i,
   output logic                           comma_hit_o,
   output qeciphy_rx_word_pkg::rx_lane_t  comma_lane_o
);

   localparam int LANES  = qeciphy_rx_word_pkg::RX_LANES;
   localparam int BYTE_W = qeciphy_rx_word_pkg::RX_WORD_W / LANES;

   qeciphy_rx_word_pkg::rx_word_t word_q;
   logic [LANES-1:0]              lane_match;
   logic                          hit;
   qeciphy_rx_word_pkg::rx_lane_t lane;

   // Word capture
   always_ff @(posedge rx_clk_2x_o) begin
      word_q <= rx_tdata_i;
   end

   // Per lane compare against the comma byte
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         lane_match[i] = (word_q[i*BYTE_W +: BYTE_W] == qeciphy_rx_word_pkg::COMMA_K28_5);
      end
   end

   assign hit = |lane_match;

   // Lowest matching lane wins
   always_comb begin
      lane = '0;
      for (int i = LANES - 1; i >= 0; i--) begin
         if (lane_match[i]) begin
            lane = qeciphy_rx_word_pkg::rx_lane_t'(i);
         end
      end
   end

   always_ff @(posedge rx_clk_2x_o or negedge gt_rst_n_i) begin
      if (!gt_rst_n_i) begin
         comma_hit_o  <= 1'b0;
         comma_lane_o <= '0;
      end else begin
         comma_hit_o  <= hit;
         comma_lane_o <= lane;
      end
   end

endmodule

// File: rtl/qeciphy_rx_ctrl_pkg.sv
// ----------------------------------------
// Alignment control package
// Tracker states, verdicts and reset hold
// ----------------------------------------

package qeciphy_rx_ctrl_pkg;

   // ----------------------------------------
   // Retry bookkeeping
   // ----------------------------------------

   // Holds MAX_RETRIES values up to 63
   typedef logic [5:0] retry_cnt_t;

   // Cycles the rx datapath reset stays low per retry
   localparam int RST_HOLD_CYCLES = 16;

   typedef logic [4:0] hold_cnt_t;

   // ----------------------------------------
   // Tracker encodings
   // ----------------------------------------

   // One-cycle result of a seek and review run
   typedef enum logic [1:0] {
      VERDICT_NONE = 2'd0,
      VERDICT_PASS = 2'd1,
      VERDICT_FAIL = 2'd2
   } verdict_t;

   typedef enum logic [1:0] {
      TRK_IDLE   = 2'd0,
      TRK_SEEK   = 2'd1,
      TRK_REVIEW = 2'd2,
      TRK_DONE   = 2'd3
   } track_state_t;

endpackage

// File: rtl/qeciphy_rx_word_pkg.sv
// ----------------------------------------
// Receive word package
// Word width, byte lanes and comma value
// ----------------------------------------

package qeciphy_rx_word_pkg;

   // ----------------------------------------
   // Word format
   // ----------------------------------------

   // One received word per recovered clock cycle
   localparam int RX_WORD_W = 32;

   // Byte lanes in a word, lane 0 in the low byte
   localparam int RX_LANES = 4;

   typedef logic [RX_WORD_W-1:0] rx_word_t;

   // Index of a byte lane within a word
   typedef logic [$clog2(RX_LANES)-1:0] rx_lane_t;

   // ----------------------------------------
   // Control characters
   // ----------------------------------------

   // K28.5 as seen after 8b10b decoding
   localparam logic [7:0] COMMA_K28_5 = 8'hBC;

endpackage
